// ==== compile.f ====
source/zxuno_map_pkg.sv
source/zxuno_cfg_pkg.sv
source/zxuno_regs.sv
source/coreid.sv
source/scratch_register.sv
source/scandoubler_ctrl.sv
source/zxuno_regbank.sv
test/tb_zxuno_regbank.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_zxuno_regbank \
   -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "All checks passed" sim.log; then
   exit 0
else
   echo "Pass message not found in sim.log"
   exit 1
fi

// ==== source/coreid.sv ====
`timescale 1ns/100ps
`default_nettype none

module coreid import zxuno_map_pkg::*, zxuno_cfg_pkg::*; #(
   // First character in the top byte, unused bytes zero
   parameter logic [8*max_coreid_len-1:0] core_id =
      {"T01-rb", {(8*max_coreid_len-48){1'b0}}},
   parameter int core_id_len = 6
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] addr,
   input  logic       zxuno_regrd,
   input  logic       regaddr_changed,
   input  logic       rd_active,
   output logic [7:0] dout,
   output logic       oe_n
);

   localparam int ptr_w = $clog2(max_coreid_len + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(core_id_len);  // Zero byte position

   logic [ptr_w-1:0]            ptr;
   logic [8*max_coreid_len-1:0] id_window;
   logic                        sel;

   assign sel = (addr == reg_coreid);

   // Current character moved up to the top byte
   always_comb begin
      id_window = core_id << (8 * ptr);
   end

   assign dout = (ptr == last_ptr) ? 8'h00 : id_window[8*max_coreid_len-1 -: 8];
   assign oe_n = ~(rd_active & sel);

   // --------------------
   // Character pointer
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (regaddr_changed) begin
         ptr <= '0;                 // New selection restarts the string
      end else if (zxuno_regrd && sel) begin
         if (ptr == last_ptr)
            ptr <= '0;              // Wrap after the zero byte
         else
            ptr <= ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== source/scandoubler_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module scandoubler_ctrl import zxuno_map_pkg::*, zxuno_cfg_pkg::*; #(
   parameter logic [7:0] scndbl_reset = 8'h00
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] addr,
   input  logic       rd_active,
   input  logic       zxuno_regwr,
   input  logic [7:0] din,
   output logic [7:0] dout,
   output logic       oe_n,
   output logic       vga_enable,
   output logic       scanlines_enable,
   output logic [1:0] freq_option,
   output logic       turbo_enable
);

   scndbl_ctrl_u ctrl;
   logic         sel;

   assign sel = (addr == reg_scndbl_ctrl);

   // --------------------
   // Control byte
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n)
         ctrl.raw <= scndbl_reset;
      else if (zxuno_regwr && sel)
         ctrl.raw <= din;   // Reserved bits stored too
   end

   // Readback of the whole byte
   assign dout = ctrl.raw;
   assign oe_n = ~(rd_active & sel);

   // --------------------
   // Video and turbo
   // --------------------

   assign vga_enable       = ctrl.fields.vga_enable;
   assign scanlines_enable = ctrl.fields.scanlines_enable;
   assign freq_option      = ctrl.fields.freq_option;
   assign turbo_enable     = ctrl.fields.turbo_enable;

endmodule

`default_nettype wire

// ==== source/scratch_register.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free byte for handing values between boot stages

module scratch_register import zxuno_map_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] addr,
   input  logic       zxuno_regrd_active,
   input  logic       zxuno_regwr,
   input  logic [7:0] din,
   output logic [7:0] dout,
   output logic       oe_n
);

   logic [7:0] scratch;
   logic       sel;

   assign sel = (addr == reg_scratch);

   always_ff @(posedge clk) begin
      if (!rst_n)
         scratch <= 8'h00;
      else if (zxuno_regwr && sel)
         scratch <= din;
   end

   // Read path
   assign dout = scratch;
   assign oe_n = ~(zxuno_regrd_active & sel);

endmodule

`default_nettype wire

// ==== source/zxuno_cfg_pkg.sv ====
`default_nettype none

// Configuration types shared by the register devices

package zxuno_cfg_pkg;

   // Longest core name the coreid pointer can index
   localparam int max_coreid_len = 32;

   // --------------------
   // Scandoubler control
   // --------------------

   // Raw view for CPU readback, field view for the video outputs
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [1:0] freq_option;       // Vertical refresh select
         logic [2:0] reserved;          // Kept as written
         logic       scanlines_enable;  // Dark every other VGA line
         logic       turbo_enable;      // Faster CPU clock
         logic       vga_enable;        // 0 gives the RGB/PAL path
      } fields;
   } scndbl_ctrl_u;

endpackage

`default_nettype wire

// ==== source/zxuno_map_pkg.sv ====
`default_nettype none

// Z80 I/O port numbers and register numbers of the ZX-Uno register bank

package zxuno_map_pkg;

   // --------------------
   // Z80 I/O ports
   // --------------------

   // Register number is written here, and read back from here
   localparam logic [15:0] io_addr_port = 16'hFC3B;

   // Selected register is read or written here
   localparam logic [15:0] io_data_port = 16'hFD3B;

   // --------------------
   // Register numbers
   // --------------------

   // Video output and CPU speed control
   localparam logic [7:0] reg_scndbl_ctrl = 8'h0B;

   // Free byte for the firmware
   localparam logic [7:0] reg_scratch = 8'hFE;

   // Core name, one character per read
   localparam logic [7:0] reg_coreid = 8'hFF;

   // Numbers 00..FF not listed above are unmapped.
   // A read of an unmapped register leaves the CPU bus undriven,
   // so the top level returns FF.

endpackage

`default_nettype wire

// ==== source/zxuno_regbank.sv ====
`timescale 1ns/100ps
`default_nettype none

module zxuno_regbank import zxuno_cfg_pkg::*; #(
   parameter logic [8*max_coreid_len-1:0] core_id =
      {"T01-rb", {(8*max_coreid_len-48){1'b0}}},
   parameter int         core_id_len  = 6,
   parameter logic [7:0] scndbl_reset = 8'h00
) (
   input  logic        clk,
   input  logic        rst_n,
   // Z80 side
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe_n,
   // Scandoubler control
   output logic        vga_enable,
   output logic        scanlines_enable,
   output logic [1:0]  freq_option,
   output logic        turbo_enable
);

   // Register decoder
   logic [7:0] zxuno_addr;
   logic [7:0] dout_addr;
   logic       oe_n_addr;
   logic       rd_active;
   logic       zxuno_regrd;
   logic       zxuno_regwr;
   logic       regaddr_changed;

   // Devices
   logic [7:0] dout_coreid;
   logic       oe_n_coreid;
   logic [7:0] dout_scratch;
   logic       oe_n_scratch;
   logic [7:0] dout_scndbl;
   logic       oe_n_scndbl;

   zxuno_regs regs_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .a               (a),
      .iorq_n          (iorq_n),
      .rd_n            (rd_n),
      .wr_n            (wr_n),
      .din             (din),
      .dout            (dout_addr),
      .oe_n            (oe_n_addr),
      .addr            (zxuno_addr),
      .rd_active       (rd_active),
      .read_from_reg   (zxuno_regrd),
      .write_to_reg    (zxuno_regwr),
      .regaddr_changed (regaddr_changed)
   );

   coreid #(
      .core_id     (core_id),
      .core_id_len (core_id_len)
   ) coreid_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .addr            (zxuno_addr),
      .zxuno_regrd     (zxuno_regrd),
      .regaddr_changed (regaddr_changed),
      .rd_active       (rd_active),
      .dout            (dout_coreid),
      .oe_n            (oe_n_coreid)
   );

   scratch_register scratch_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .addr               (zxuno_addr),
      .zxuno_regrd_active (rd_active),
      .zxuno_regwr        (zxuno_regwr),
      .din                (din),
      .dout               (dout_scratch),
      .oe_n               (oe_n_scratch)
   );

   scandoubler_ctrl #(
      .scndbl_reset (scndbl_reset)
   ) scndbl_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .addr             (zxuno_addr),
      .rd_active        (rd_active),
      .zxuno_regwr      (zxuno_regwr),
      .din              (din),
      .dout             (dout_scndbl),
      .oe_n             (oe_n_scndbl),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .freq_option      (freq_option),
      .turbo_enable     (turbo_enable)
   );

   // --------------------
   // CPU read data
   // --------------------

   assign oe_n = oe_n_addr & oe_n_coreid & oe_n_scratch & oe_n_scndbl;

   always_comb begin
      if (!oe_n_addr)
         dout = dout_addr;
      else if (!oe_n_coreid)
         dout = dout_coreid;
      else if (!oe_n_scratch)
         dout = dout_scratch;
      else if (!oe_n_scndbl)
         dout = dout_scndbl;
      else
         dout = 8'hFF;    // Undriven bus
   end

endmodule

`default_nettype wire

// ==== source/zxuno_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module zxuno_regs import zxuno_map_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe_n,
   output logic [7:0]  addr,
   output logic        rd_active,        // Data port read in progress
   output logic        read_from_reg,
   output logic        write_to_reg,
   output logic        regaddr_changed
);

   logic hit_addr_port;
   logic hit_data_port;
   logic io_rd;
   logic io_wr;
   logic addr_rd;
   logic addr_wr;
   logic data_wr;

   logic addr_wr_q;
   logic data_wr_q;
   logic data_rd_q;
   logic addr_load;   // Second cycle of an FC3B write

   // --------------------
   // Bus decode
   // --------------------

   assign hit_addr_port = (a == io_addr_port);
   assign hit_data_port = (a == io_data_port);
   assign io_rd         = ~iorq_n & ~rd_n;
   assign io_wr         = ~iorq_n & ~wr_n;

   assign addr_rd   = hit_addr_port & io_rd;
   assign addr_wr   = hit_addr_port & io_wr;
   assign data_wr   = hit_data_port & io_wr;
   assign rd_active = hit_data_port & io_rd;

   // FC3B reads return the current register number
   assign dout = addr;
   assign oe_n = ~addr_rd;

   // --------------------
   // Access edges
   // --------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addr_wr_q       <= 1'b0;
         data_wr_q       <= 1'b0;
         data_rd_q       <= 1'b0;
         addr_load       <= 1'b0;
         addr            <= 8'h00;
         write_to_reg    <= 1'b0;
         read_from_reg   <= 1'b0;
         regaddr_changed <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         data_wr_q <= data_wr;
         data_rd_q <= rd_active;

         addr_load     <= addr_wr & ~addr_wr_q;    // Start of FC3B write
         write_to_reg  <= data_wr & ~data_wr_q;    // Start of FD3B write
         read_from_reg <= data_rd_q & ~rd_active;  // End of FD3B read

         // din is still held in the second cycle of the access
         if (addr_load)
            addr <= din;
         regaddr_changed <= addr_load;
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_zxuno_regbank.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_zxuno_regbank
   import zxuno_map_pkg::*, zxuno_cfg_pkg::*;
();

   localparam int          clk_period     = 8;
   localparam int          reset_cycles   = 16;
   localparam int          n_random_ops   = 300;
   localparam int          n_directed_ops = 300;   // Upper bound for the directed phases
   localparam int          op_cycles      = 5 + 2; // Longest access plus bus gap
   localparam int          watchdog_ns    =
      (reset_cycles + (n_random_ops + n_directed_ops) * op_cycles) * clk_period + 2000;
   localparam logic [47:0] id_text = "T01-rb";
   localparam int          id_len  = 6;

   logic        clk;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        oe_n;
   logic        vga_enable;
   logic        scanlines_enable;
   logic [1:0]  freq_option;
   logic        turbo_enable;

   // Shadow model of the register bank
   logic [7:0]   m_addr;
   logic [7:0]   m_scratch;
   scndbl_ctrl_u m_ctrl;
   int           m_ptr;     // Core name character pointer
   int           errors;
   int           checks;

   zxuno_regbank zxuno_regbank_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .a                (a),
      .iorq_n           (iorq_n),
      .rd_n             (rd_n),
      .wr_n             (wr_n),
      .din              (din),
      .dout             (dout),
      .oe_n             (oe_n),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .freq_option      (freq_option),
      .turbo_enable     (turbo_enable)
   );

   always #(clk_period / 2) clk = ~clk;

   // --------------------
   // Bus cycles
   // --------------------

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
      end
   endtask

   // Nothing may drive the CPU on an idle bus
   task automatic bus_gap();
      @(negedge clk);
      check_value("oe_n", 8'h01, {7'b0, oe_n});
      check_value("dout", 8'hFF, dout);
      @(negedge clk);
   endtask

   task automatic io_write(input logic [15:0] port, input logic [7:0] data);
      int len;
      len    = 2 + int'($urandom_range(3));
      a      = port;
      din    = data;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      repeat (len) @(negedge clk);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      bus_gap();
   endtask

   task automatic io_read(input logic [15:0] port, input logic [7:0] exp_data,
                          input logic exp_oe_n);
      int len;
      len    = 2 + int'($urandom_range(3));
      a      = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      @(negedge clk);              // First cycle of the access
      check_value("oe_n", {7'b0, exp_oe_n}, {7'b0, oe_n});
      check_value("dout", exp_data, dout);
      repeat (len - 1) @(negedge clk);
      check_value("oe_n", {7'b0, exp_oe_n}, {7'b0, oe_n});
      check_value("dout", exp_data, dout);
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      bus_gap();
   endtask

   // --------------------
   // Model operations
   // --------------------

   // Control byte bits 0, 1, 2 and 7:6 drive the outputs
   task automatic check_outputs();
      check_value("vga_enable", {7'b0, m_ctrl.raw[0]}, {7'b0, vga_enable});
      check_value("scanlines_enable", {7'b0, m_ctrl.raw[2]}, {7'b0, scanlines_enable});
      check_value("turbo_enable", {7'b0, m_ctrl.raw[1]}, {7'b0, turbo_enable});
      check_value("freq_option", {6'b0, m_ctrl.raw[7:6]}, {6'b0, freq_option});
   endtask

   task automatic select_reg(input logic [7:0] num);
      io_write(io_addr_port, num);
      m_addr = num;
      m_ptr  = 0;                  // Any selection restarts the core name
   endtask

   task automatic write_reg(input logic [7:0] value);
      io_write(io_data_port, value);
      if (m_addr == reg_scratch)
         m_scratch = value;
      else if (m_addr == reg_scndbl_ctrl)
         m_ctrl.raw = value;
      check_outputs();
   endtask

   task automatic read_addr_reg();
      io_read(io_addr_port, m_addr, 1'b0);
   endtask

   task automatic read_reg();
      logic [7:0] expected;
      logic       mapped;
      mapped = 1'b1;
      if (m_addr == reg_coreid)
         expected = (m_ptr == id_len) ? 8'h00 : id_text[8*(id_len-1-m_ptr) +: 8];
      else if (m_addr == reg_scratch)
         expected = m_scratch;
      else if (m_addr == reg_scndbl_ctrl)
         expected = m_ctrl.raw;
      else begin
         expected = 8'hFF;         // Unmapped register leaves the bus floating
         mapped   = 1'b0;
      end
      io_read(io_data_port, expected, ~mapped);
      if (m_addr == reg_coreid)
         m_ptr = (m_ptr == id_len) ? 0 : m_ptr + 1;
   endtask

   function automatic logic [7:0] unmapped_reg();
      logic [7:0] num;
      do
         num = 8'($urandom());
      while (num == reg_coreid || num == reg_scratch || num == reg_scndbl_ctrl);
      return num;
   endfunction

   function automatic logic [7:0] random_reg();
      case ($urandom_range(3))
         0:       return reg_coreid;
         1:       return reg_scratch;
         2:       return reg_scndbl_ctrl;
         default: return 8'($urandom());
      endcase
   endfunction

   // --------------------
   // Test sequence
   // --------------------

   initial begin
      int k;
      clk        = 1'b0;
      rst_n      = 1'b0;
      a          = 16'h0000;
      iorq_n     = 1'b1;
      rd_n       = 1'b1;
      wr_n       = 1'b1;
      din        = 8'h00;
      errors     = 0;
      checks     = 0;
      m_addr     = 8'h00;
      m_scratch  = 8'h00;
      m_ctrl.raw = 8'h00;          // Default scndbl_reset
      m_ptr      = 0;
      void'($urandom(32'ha123_89e0));
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      check_value("oe_n", 8'h01, {7'b0, oe_n});
      check_outputs();
      read_addr_reg();

      repeat (16) begin            // Address port and unmapped reads
         select_reg(random_reg());
         read_addr_reg();
         select_reg(unmapped_reg());
         read_reg();
      end

      repeat (16) begin            // Scratch with other traffic between
         select_reg(reg_scratch);
         write_reg(8'($urandom()));
         select_reg(unmapped_reg());
         write_reg(8'($urandom()));
         select_reg(reg_scratch);
         read_reg();
      end

      select_reg(reg_scndbl_ctrl);
      repeat (16) begin
         write_reg(8'($urandom()));
         read_reg();
      end

      select_reg(reg_coreid);
      repeat (2 * (id_len + 1) + 1) read_reg();   // Twice round plus the wrap

      for (k = 1; k < id_len; k++) begin
         select_reg(reg_coreid);
         repeat (k) read_reg();
         select_reg(reg_scratch);
         select_reg(reg_coreid);   // Back to the first character
         read_reg();
         read_reg();
      end

      repeat (n_random_ops) begin
         case ($urandom_range(4))
            0:       select_reg(random_reg());
            1:       write_reg(8'($urandom()));
            2, 3:    read_reg();
            default: read_addr_reg();
         endcase
      end

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("Timeout: the test sequence did not finish within %0d ns", watchdog_ns);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
